// ==== files.f ====
icache_pkg.sv
icache_req_latch.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_ctrl.sv
icache_word_sel.sv
icache_top.sv
icache_mem_model.sv
icache_tb.sv

// ==== icache_tb.sv ====
// testbench for the instruction cache
// clock and reset, fetch tasks, reference data and tag model,
// response checker and final report
`timescale 1ns/10ps
`default_nettype none

module icache_tb
  import icache_pkg::*;
();

  localparam int limit = 400; // cycles allowed per wait loop

  logic        clk;
  logic        rst_n;
  logic        fetch_req;
  logic [31:0] fetch_addr;
  logic        flush;
  logic        mem_resp;
  line_t       mem_line;
  logic        stall;
  logic        resp_valid;
  logic [31:0] resp_data;
  logic        mem_req;
  mem_req_t    mem_req_addr;
  mem_req_t    fill_addr;
  line_t       fill;

  logic [31:0] exp_q [$];  // expected words, in fetch order
  int          cyc_q [$];  // issue cycle per fetch
  int          lat_q [$];  // required latency, 0 when free
  logic [19:0] m_tag [256];
  logic        m_vld [256];
  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          req_cnt = 0;
  int          exp_reqs = 0; // misses the tag model predicts
  int          resp_cnt = 0;
  int          t_err;
  int          t_req;
  int          t_xreq;
  logic        stall_seen;
  mem_req_t    last_req;
  logic [31:0] rng;

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [31:0] w;
    w = {2'b00, addr[31:2]}; // word address
    return (w * 32'h9e3779b1) ^ {w[12:0], w[31:13]} ^ 32'h5a5a0f0f;
  endfunction

  function automatic line_t ref_line(input logic [27:0] la);
    line_t l;
    for (int i = 0; i < 4; i++) l[i] = ref_word({la, 4'h0} + 4 * i);
    return l;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  assign fill = ref_line(fill_addr.line_addr); // bank contents

  icache_top #(.lines(256)) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .flush        (flush),
    .mem_resp     (mem_resp),
    .mem_line     (mem_line),
    .stall        (stall),
    .resp_valid   (resp_valid),
    .resp_data    (resp_data),
    .mem_req      (mem_req),
    .mem_req_addr (mem_req_addr)
  );

  icache_mem_model u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req      (mem_req),
    .mem_req_addr (mem_req_addr),
    .fill         (fill),
    .fill_addr    (fill_addr),
    .mem_resp     (mem_resp),
    .mem_line     (mem_line)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic give_up(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("TEST FAILED");
    $finish;
  endtask

  // cycle count, memory requests, stall history
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (rst_n && mem_req) begin
      req_cnt  <= req_cnt + 1;
      last_req <= mem_req_addr;
    end
    if (stall) stall_seen <= 1'b1;
  end

  // every response pops one expected word
  always @(posedge clk) begin : compare
    int lat;
    int want;
    if (rst_n && resp_valid) begin
      resp_cnt++; // every strobe, matched or not
      if (exp_q.size() == 0) begin
        errors++;
        $display("response at %0t with no fetch outstanding", $time);
      end else begin
        check_eq("resp_data", resp_data, exp_q.pop_front());
        lat  = cyc - cyc_q.pop_front();
        want = lat_q.pop_front();
        if (want != 0) check_eq("hit latency", lat, want);
      end
    end
  end

  task automatic fetch(input logic [31:0] addr, input int lat);
    int         n;
    logic [7:0] idx;
    n   = 0;
    idx = addr[11:4];
    @(negedge clk);
    fetch_req = 1'b0;
    while (stall) begin // strobes are not taken during stall
      n++;
      if (n > limit) give_up("stall stayed high before a fetch");
      @(negedge clk);
    end
    fetch_req  = 1'b1;
    fetch_addr = addr;
    exp_q.push_back(ref_word(addr));
    cyc_q.push_back(cyc);
    lat_q.push_back(lat);
    if (!m_vld[idx] || m_tag[idx] != addr[31:12]) begin
      exp_reqs++; // model miss, line now resident
      m_vld[idx] = 1'b1;
      m_tag[idx] = addr[31:12];
    end
  endtask

  task automatic idle();
    @(negedge clk);
    fetch_req = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    idle();
    while (exp_q.size() != 0 || stall) begin
      n++;
      if (n > limit) give_up("responses still missing");
      @(negedge clk);
    end
  endtask

  task automatic do_flush();
    drain();
    flush = 1'b1;
    for (int i = 0; i < 256; i++) m_vld[i] = 1'b0;
    @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic begin_test();
    t_err  = errors;
    t_req  = req_cnt;
    t_xreq = exp_reqs;
  endtask

  task automatic end_test(input string name);
    drain();
    check_eq("mem_req count", req_cnt - t_req, exp_reqs - t_xreq);
    $display("%-20s done at %0t, %0d errors", name, $time, errors - t_err);
  endtask

  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] addr;
    int          n0;
    rst_n      = 1'b0;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    flush      = 1'b0;
    stall_seen = 1'b0;
    rng        = 32'hdab5e9f4;
    for (int i = 0; i < 256; i++) m_vld[i] = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    a = 32'h0001_2340;
    b = 32'h0001_2350;     // neighbour line
    c = a ^ 32'h0007_0000; // same index, other tag
    d = 32'h0042_1880;

    begin_test();
    stall_seen = 1'b0;
    fetch(a, 0);
    drain();
    check_eq("cold miss mem_req", req_cnt - t_req, 1);
    check_eq("line address", last_req.line_addr, a[31:4]);
    check_eq("stall raised", stall_seen, 1'b1);
    end_test("cold miss");

    begin_test();
    for (int w = 0; w < 4; w++) begin
      fetch(a + 4 * w, 2);
      drain();
    end
    check_eq("hit mem_req", req_cnt - t_req, 0);
    end_test("line hits");

    begin_test();
    fetch(b, 0);
    drain();
    n0 = resp_cnt;
    for (int k = 0; k < 8; k++) fetch(((k % 2) == 1 ? b : a) + 4 * (k / 2), 2);
    drain();
    idle();
    idle();
    check_eq("burst responses", resp_cnt - n0, 8);
    end_test("back-to-back hits");

    begin_test();
    fetch(c, 0);
    drain();
    fetch(a, 0);
    drain();
    fetch(c, 0);
    drain();
    check_eq("conflict mem_req", req_cnt - t_req, 3);
    fetch(d, 0);
    fetch(d + 8, 0);     // held behind the miss, replayed
    fetch(d + 16, 0);
    end_test("conflict and replay");

    begin_test();
    do_flush();
    fetch(c, 0);         // both lines resident before the flush
    fetch(b, 0);
    drain();
    check_eq("misses after flush", req_cnt - t_req, 2);
    end_test("flush");

    begin_test();
    for (int k = 0; k < 300; k++) begin
      rng  = xorshift(rng);
      addr = {rng[31:30], 18'h00120, rng[11:2], 2'b00}; // four tags, any index
      fetch(addr, 0);
      if (rng[15:13] == 3'd0) idle();
    end
    end_test("random run");

    $display("%0d checks, %0d errors, %0d mem_req", checks, errors, req_cnt);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== icache_mem_model.sv ====
// next-level memory model for the testbench
// one line request at a time, answered after 1 to 8 cycles
`timescale 1ns/10ps
`default_nettype none

module icache_mem_model
  import icache_pkg::*;
#(
  parameter logic [31:0] seed = 32'hdab5e9f4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     mem_req,      // one cycle per miss
  input  mem_req_t mem_req_addr,
  input  line_t    fill,         // four bank words at fill_addr
  output mem_req_t fill_addr,    // line being fetched
  output logic     mem_resp,
  output line_t    mem_line
);

  logic [31:0] rng;      // latency generator
  logic        pending;  // request accepted, not yet answered
  int          wait_cyc; // cycles left before the answer

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    rng       = seed;
    pending   = 1'b0;
    wait_cyc  = 0;
    fill_addr = '0;
    mem_resp  = 1'b0;
    mem_line  = '0;
  end

  // outputs change on the falling edge only
  always @(negedge clk) begin
    mem_resp = 1'b0;
    if (!rst_n) begin
      pending = 1'b0;
    end else begin
      if (pending) begin
        if (wait_cyc == 0) begin
          mem_resp = 1'b1; // line valid this cycle
          mem_line = fill;
          pending  = 1'b0;
        end else begin
          wait_cyc--;
        end
      end
      if (mem_req) begin
        rng       = xorshift(rng);
        wait_cyc  = rng[2:0]; // 1 to 8 cycles after mem_req
        pending   = 1'b1;
        fill_addr = mem_req_addr;
      end
    end
  end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
// L1 instruction cache top level
// request latch, tag and data arrays, controller, word selector
`timescale 1ns/10ps
`default_nettype none

module icache_top
  import icache_pkg::*;
#(
  parameter int lines = 256
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_req,    // strobe, ignored while stall
  input  logic [31:0] fetch_addr,
  input  logic        flush,        // strobe, clears all valid bits
  input  logic        mem_resp,     // strobe, mem_line valid
  input  line_t       mem_line,
  output logic        stall,
  output logic        resp_valid,
  output logic [31:0] resp_data,
  output logic        mem_req,      // one cycle per miss
  output mem_req_t    mem_req_addr
);

  fetch_addr_t        stage_a;
  fetch_addr_t        stage_b;
  logic               stage_a_vld;
  logic               stage_b_vld;
  logic               replay;
  logic [index_w-1:0] array_index;
  logic               array_we;
  logic [tag_w-1:0]   tag_wd;
  logic [tag_w-1:0]   tag_rd;
  logic               valid;
  line_t              line_rd;
  logic               sel_fire;
  logic [offset_w-1:0] sel_word;
  logic               sel_refill;

  icache_req_latch u_req_latch (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .hold        (stall),        // stall freezes the pipe
    .replay      (replay),
    .stage_a     (stage_a),
    .stage_a_vld (stage_a_vld),
    .stage_b     (stage_b),
    .stage_b_vld (stage_b_vld)
  );

  icache_tag_ram #(.lines(lines)) u_tag_ram (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush  (flush),
    .index  (array_index),
    .we     (array_we),
    .tag_wd (tag_wd),
    .tag_rd (tag_rd),
    .valid  (valid)
  );

  icache_data_ram #(.lines(lines)) u_data_ram (
    .clk   (clk),
    .index (array_index),
    .we    (array_we),
    .wd    (mem_line),   // refill written straight from the bus
    .rd    (line_rd)
  );

  icache_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .stage_a      (stage_a),
    .stage_a_vld  (stage_a_vld),
    .stage_b      (stage_b),
    .stage_b_vld  (stage_b_vld),
    .tag_rd       (tag_rd),
    .valid        (valid),
    .mem_resp     (mem_resp),
    .array_index  (array_index),
    .array_we     (array_we),
    .tag_wd       (tag_wd),
    .hold         (stall),
    .replay       (replay),
    .mem_req      (mem_req),
    .mem_req_addr (mem_req_addr),
    .sel_fire     (sel_fire),
    .sel_word     (sel_word),
    .sel_refill   (sel_refill)
  );

  icache_word_sel u_word_sel (
    .clk         (clk),
    .rst_n       (rst_n),
    .fire        (sel_fire),
    .word        (sel_word),
    .use_refill  (sel_refill),
    .line_rd     (line_rd),
    .refill_line (mem_line),   // same line the array stores
    .resp_valid  (resp_valid),
    .resp_data   (resp_data)
  );

endmodule

`default_nettype wire

// ==== icache_word_sel.sv ====
// response word select
// holds the refill line, picks array or refill line and the addressed word
`timescale 1ns/10ps
`default_nettype none

module icache_word_sel
  import icache_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fire,        // answer this cycle
  input  logic [offset_w-1:0] word,
  input  logic                use_refill,  // without fire it loads the line
  input  line_t               line_rd,     // from data array
  input  line_t               refill_line, // from next level
  output logic                resp_valid,
  output logic [31:0]         resp_data
);

  line_t refill_q; // line kept for the answer after mem_resp
  line_t src;      // selected source line

  // captured in the mem_resp cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refill_q <= '0;
    end else if (use_refill && !fire) begin
      refill_q <= refill_line;
    end
  end

  assign src = use_refill ? refill_q : line_rd; // refill answer skips the array

  assign resp_valid = fire;
  assign resp_data  = src[word]; // addressed 32-bit word

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
// cache controller
// tag compare on stage_b, miss and refill FSM, memory line request,
// array addressing and response control for the word selector
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  fetch_addr_t        stage_a,
  input  logic               stage_a_vld,
  input  fetch_addr_t        stage_b,
  input  logic               stage_b_vld,
  input  logic [tag_w-1:0]   tag_rd,       // tag of stage_b's line
  input  logic               valid,        // valid of stage_b's line
  input  logic               mem_resp,     // line arrives
  output logic [index_w-1:0] array_index,
  output logic               array_we,
  output logic [tag_w-1:0]   tag_wd,
  output logic               hold,         // also the stall output
  output logic               replay,
  output logic               mem_req,      // one cycle per miss
  output mem_req_t           mem_req_addr,
  output logic               sel_fire,     // response this cycle
  output logic [offset_w-1:0] sel_word,
  output logic               sel_refill    // use refill line
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        hit;      // stage_b found in cache
  logic        miss_now; // stage_b needs a refill

  // compare against the line read at the last edge
  assign hit      = stage_b_vld & valid & (tag_rd == stage_b.tag);
  assign miss_now = stage_b_vld & ~hit;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      lookup: begin
        if (miss_now) state_d = miss_req;
      end
      miss_req: begin
        state_d = miss_wait;  // request sent this cycle
      end
      miss_wait: begin
        if (mem_resp) state_d = refill_wr; // line written now
      end
      refill_wr: begin
        state_d = lookup;     // pipe restarts
      end
      default: begin
        state_d = lookup;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= lookup;
    else        state_q <= state_d;
  end

  // stall rises with the miss, falls while answering from refill
  always_comb begin
    case (state_q)
      lookup:    hold = miss_now;
      refill_wr: hold = 1'b0;
      default:   hold = 1'b1;
    endcase
  end

  assign replay = (state_q == refill_wr);

  // arrays follow stage_a in the pipe, stage_b while refilling
  always_comb begin
    if (state_q == lookup || state_q == refill_wr) begin
      // falls back to stage_b when stage_a is empty
      array_index = stage_a_vld ? stage_a.index : stage_b.index;
    end else begin
      array_index = stage_b.index; // write target
    end
  end

  assign array_we = (state_q == miss_wait) & mem_resp; // tag and line together
  assign tag_wd   = stage_b.tag;

  // memory side, address held stable by the frozen latch
  assign mem_req                = (state_q == miss_req);
  assign mem_req_addr.line_addr = {stage_b.tag, stage_b.index};

  // word selector control
  assign sel_fire   = ((state_q == lookup) & hit) | (state_q == refill_wr);
  assign sel_word   = stage_b.word;
  assign sel_refill = array_we | (state_q == refill_wr); // capture, then use

endmodule

`default_nettype wire

// ==== icache_data_ram.sv ====
// cache line array, registered read, whole-line write
`timescale 1ns/10ps
`default_nettype none

module icache_data_ram
  import icache_pkg::*;
#(
  parameter int lines = 256
) (
  input  logic               clk,
  input  logic [index_w-1:0] index,
  input  logic               we,  // refill write
  input  line_t              wd,
  output line_t              rd
);

  localparam int addr_w = $clog2(lines);

  line_t             data_mem [lines]; // line storage
  logic [addr_w-1:0] addr;

  assign addr = index[addr_w-1:0];

  always_ff @(posedge clk) begin
    if (we) data_mem[addr] <= wd; // full line replace
    rd <= data_mem[addr];
  end

endmodule

`default_nettype wire

// ==== icache_tag_ram.sv ====
// tag array with registered read
// valid bits kept in flops so reset and flush clear them at once
`timescale 1ns/10ps
`default_nettype none

module icache_tag_ram
  import icache_pkg::*;
#(
  parameter int lines = 256
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush,  // clear all valid bits
  input  logic [index_w-1:0] index,
  input  logic               we,     // store tag, mark valid
  input  logic [tag_w-1:0]   tag_wd,
  output logic [tag_w-1:0]   tag_rd,
  output logic               valid
);

  localparam int addr_w = $clog2(lines); // used index bits

  logic [tag_w-1:0] tag_mem [lines]; // tag storage
  logic [lines-1:0] vld_q;           // one bit per line
  logic [addr_w-1:0] addr;

  assign addr = index[addr_w-1:0]; // upper bits unused for small caches

  always_ff @(posedge clk) begin
    if (we) tag_mem[addr] <= tag_wd;
    tag_rd <= tag_mem[addr]; // read before write
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
      valid <= 1'b0;
    end else begin
      if (flush) vld_q <= '0;               // whole cache invalid
      else if (we) vld_q[addr] <= 1'b1;
      valid <= vld_q[addr] & ~flush;         // no stale hit right after flush
    end
  end

endmodule

`default_nettype wire

// ==== icache_req_latch.sv ====
// fetch request pipeline, two entries
// stage_a is in the array read, stage_b is in the tag compare
`timescale 1ns/10ps
`default_nettype none

module icache_req_latch
  import icache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_req,   // single-cycle strobe
  input  logic [31:0] fetch_addr,  // byte address
  input  logic        hold,        // freeze both entries
  input  logic        replay,      // end of refill, restart the pipe
  output fetch_addr_t stage_a,
  output logic        stage_a_vld,
  output fetch_addr_t stage_b,
  output logic        stage_b_vld
);

  logic advance; // pipe moves this cycle

  assign advance = ~hold | replay; // replay lets held stage_a go back through the read

  // control state, cleared by reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_a_vld <= 1'b0;
      stage_b_vld <= 1'b0;
    end else if (advance) begin
      stage_b_vld <= stage_a_vld; // entry moves into compare
      stage_a_vld <= fetch_req;   // strobes during stall never get here
    end
  end

  // address payload, no reset
  always_ff @(posedge clk) begin
    if (advance) begin
      stage_b <= stage_a;
      stage_a <= fetch_addr_t'(fetch_addr);
    end
  end

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
// shared types for the L1 instruction cache
// address field widths, fetch address split, line and memory request,
// controller state encoding
`default_nettype none

package icache_pkg;

  localparam int tag_w    = 20;  // address bits 31..12
  localparam int index_w  = 8;   // address bits 11..4
  localparam int offset_w = 2;   // word within line, bits 3..2
  localparam int line_w   = 128; // four 32-bit words

  // byte address split into cache fields
  typedef struct packed {
    logic [tag_w-1:0]    tag;   // compared against tag array
    logic [index_w-1:0]  index; // line select
    logic [offset_w-1:0] word;  // word select
    logic [1:0]          pad;   // byte bits, ignored
  } fetch_addr_t;

  // word 0 sits in the low bits
  typedef logic [3:0][31:0] line_t;

  // line request toward the next level
  typedef struct packed {
    logic [tag_w+index_w-1:0] line_addr; // tag and index
  } mem_req_t;

  // miss handling states
  typedef enum logic [1:0] {
    lookup    = 2'd0, // normal hit pipeline
    miss_req  = 2'd1, // one-cycle mem_req
    miss_wait = 2'd2, // waiting for mem_resp
    refill_wr = 2'd3  // answer from refill, restart pipe
  } ctrl_state_t;

endpackage

`default_nettype wire
